/* logic/corePkg.sv */
package corePkg;

	////////////////////
	// widths
	////////////////////

	// data and address word
	typedef logic [31:0] word;
	// register index
	typedef logic [4:0] regAddr;
	// opcode or funct field
	typedef logic [5:0] opField;

	// alu operations
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOp;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSel;

	////////////////////
	// instruction fields
	////////////////////

	localparam opField opRtype = 6'h00;
	localparam opField opJ     = 6'h02;
	localparam opField opBeq   = 6'h04;
	localparam opField opAddiu = 6'h09;
	localparam opField opLw    = 6'h23;
	localparam opField opSw    = 6'h2b;

	// funct values under opRtype
	localparam opField fnJr   = 6'h08;
	localparam opField fnAddu = 6'h21;
	localparam opField fnSubu = 6'h23;
	localparam opField fnAnd  = 6'h24;
	localparam opField fnOr   = 6'h25;
	localparam opField fnSlt  = 6'h2a;

	////////////////////
	// pipeline registers
	////////////////////

	// all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic branch;
		logic jump;
		logic jumpReg;
		logic aluSrcImm;
		logic regDst;
		aluOp aluOp;
	} decodeCtrl;

	typedef struct packed {
		decodeCtrl ctrl;
		word       pcPlus4;
		word       opA;
		word       opB;
		word       imm;
		regAddr    rs;
		regAddr    rt;
		regAddr    rd;
	} decodeToExec;

	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		word    aluResult;
		word    storeData;
		regAddr dest;
	} execToMem;

	typedef struct packed {
		logic   regWrite;
		word    result;
		regAddr dest;
	} memToWb;

endpackage

/* logic/hazardUnit.sv */
module hazardUnit (
	input  logic            clk,
	input  logic            reset,
	// decode stage
	input  corePkg::regAddr rsD,
	input  corePkg::regAddr rtD,
	input  logic            jumpRegD,
	// execute stage
	input  corePkg::regAddr rsE,
	input  corePkg::regAddr rtE,
	input  corePkg::regAddr destE,
	input  logic            regWriteE,
	input  logic            memToRegE,
	input  logic            branchTakenE,
	// memory stage
	input  corePkg::regAddr destM,
	input  logic            regWriteM,
	input  logic            memToRegM,
	// writeback stage
	input  corePkg::regAddr destW,
	input  logic            regWriteW,
	// memory port waits
	input  logic            instrWait,
	input  logic            dataStall,
	output corePkg::fwdSel  fwdA,
	output corePkg::fwdSel  fwdB,
	output logic            fwdJr,
	output logic            stallFD,
	output logic            flushD,
	output logic            flushE,
	output logic            freeze
);
	logic loadUse;
	logic jrWaitE;
	logic jrWaitM;

	////////////////////
	// forwarding
	////////////////////

	// memory stage is younger, so it wins over writeback
	assign fwdA = (rsE != '0 && regWriteM && rsE == destM) ? corePkg::fwdMem :
		(rsE != '0 && regWriteW && rsE == destW) ? corePkg::fwdWb : corePkg::fwdReg;
	assign fwdB = (rtE != '0 && regWriteM && rtE == destM) ? corePkg::fwdMem :
		(rtE != '0 && regWriteW && rtE == destW) ? corePkg::fwdWb : corePkg::fwdReg;

	// jr target straight from the alu result in memory
	assign fwdJr = jumpRegD && rsD != '0 && regWriteM && !memToRegM && destM == rsD;

	////////////////////
	// stalls
	////////////////////

	// load in execute, consumer right behind it
	assign loadUse = memToRegE && destE != '0 && (destE == rsD || destE == rtD);

	// jr target not ready yet
	assign jrWaitE = jumpRegD && rsD != '0 && regWriteE && destE == rsD;
	// loaded target only shows up through the writeback bypass
	assign jrWaitM = jumpRegD && rsD != '0 && memToRegM && destM == rsD;

	// a taken branch squashes whatever sits in decode, no point holding it
	assign stallFD = (loadUse || jrWaitE || jrWaitM) && !branchTakenE;

	// either port waiting holds the whole pipe
	assign freeze = instrWait || dataStall;

	assign flushD = branchTakenE && !freeze;
	// bubble into execute behind a held decode
	assign flushE = stallFD && !freeze;

	// squash and hold of the decode slot must not collide
	assert property (@(posedge clk) disable iff (reset) !(flushD && stallFD));

	// register 0 is hard zero, never a forwarding target
	assert property (@(posedge clk) disable iff (reset)
		(fwdA != corePkg::fwdReg |-> rsE != '0) and
		(fwdB != corePkg::fwdReg |-> rtE != '0) and
		(fwdJr |-> rsD != '0));

endmodule

/* logic/regFile.sv */
module regFile #(
	parameter int regCount = 32
) (
	input  logic            clk,
	input  logic            writeEnable,
	input  corePkg::regAddr writeAddr,
	input  corePkg::word    writeData,
	input  corePkg::regAddr readAddrA,
	input  corePkg::regAddr readAddrB,
	output corePkg::word    readDataA,
	output corePkg::word    readDataB
);
	corePkg::word regs [regCount];
	logic bypassA;
	logic bypassB;

	// register 0 never stored
	always_ff @(posedge clk) begin
		if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write seen by decode
	assign bypassA = writeEnable && writeAddr == readAddrA;
	assign bypassB = writeEnable && writeAddr == readAddrB;

	assign readDataA = (readAddrA == '0) ? '0 :
		bypassA ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		bypassB ? writeData : regs[readAddrB];

endmodule

/* logic/alu.sv */
module alu (
	input  corePkg::aluOp op,
	input  corePkg::word  a,
	input  corePkg::word  b,
	output corePkg::word  result,
	output logic          zero
);

	always_comb begin
		case (op)
			corePkg::aluAdd: begin
				result = a + b;
			end
			corePkg::aluSub: begin
				result = a - b;
			end
			corePkg::aluAnd: begin
				result = a & b;
			end
			corePkg::aluOr: begin
				result = a | b;
			end
			// signed compare
			corePkg::aluSlt: begin
				result = {31'd0, $signed(a) < $signed(b)};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// beq equality test
	assign zero = (result == '0);

endmodule

/* logic/controlDecode.sv */
module controlDecode (
	input  corePkg::word       instr,
	output corePkg::decodeCtrl ctrl,
	output logic               illegal
);
	corePkg::opField opcode;
	corePkg::opField funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		ctrl = '0;
		illegal = 1'b0;
		case (opcode)
			corePkg::opRtype: begin
				// register-register ops write rd
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					corePkg::fnAddu: ctrl.aluOp = corePkg::aluAdd;
					corePkg::fnSubu: ctrl.aluOp = corePkg::aluSub;
					corePkg::fnAnd: ctrl.aluOp = corePkg::aluAnd;
					corePkg::fnOr: ctrl.aluOp = corePkg::aluOr;
					corePkg::fnSlt: ctrl.aluOp = corePkg::aluSlt;
					corePkg::fnJr: begin
						ctrl = '0;
						ctrl.jumpReg = 1'b1;
					end
					default: begin
						ctrl = '0;
						// all-zero word is the nop, not an error
						illegal = (instr != '0);
					end
				endcase
			end
			corePkg::opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			corePkg::opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			// address from rs plus offset, data from rt
			corePkg::opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			// subtract, zero flag decides
			corePkg::opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = corePkg::aluSub;
			end
			corePkg::opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

/* logic/apbDataPort.sv */
module apbDataPort (
	input  logic              clk,
	input  logic              reset,
	input  corePkg::execToMem req,
	input  corePkg::word      prdata,
	input  logic              pready,
	output corePkg::word      loadData,
	output logic              dataStall,
	output corePkg::word      paddr,
	output corePkg::word      pwdata,
	output logic              psel,
	output logic              penable,
	output logic              pwrite
);
	typedef enum logic {
		idle,
		access
	} portState;

	portState state;
	portState nextState;
	logic memOp;
	logic finish;
	corePkg::word loadHold;

	// load or store waiting in the memory stage
	assign memOp = req.memWrite || req.memToReg;
	assign finish = (state == access) && pready;

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (memOp) begin
					nextState = access;
				end
			end
			access: begin
				if (pready) begin
					nextState = idle;
				end
			end
			default: begin
				nextState = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	// setup cycle comes from idle with a request
	assign psel = memOp || (state == access);
	assign penable = (state == access);
	assign pwrite = psel && req.memWrite;
	// memory stage register holds these while stalled
	assign paddr = req.aluResult;
	assign pwdata = req.storeData;

	// low in the pready cycle so the stage moves at that edge
	assign dataStall = (state == idle) ? memOp : !pready;

	always_ff @(posedge clk) begin
		if (finish) begin
			loadHold <= prdata;
		end
	end

	// live data on completion, held copy while fetch keeps the pipe frozen
	assign loadData = finish ? prdata : loadHold;

	// nothing moves under the slave until it answers
	assert property (@(posedge clk) disable iff (reset)
		psel && !finish |=> psel && penable && $stable(paddr) && $stable(pwrite));

endmodule

/* logic/mipsCore.sv */
module mipsCore #(
	parameter corePkg::word resetPc = '0,
	parameter int regCount = 32
) (
	input  logic         clk,
	input  logic         reset,
	// instruction fetch port
	output corePkg::word instrAddr,
	input  corePkg::word instrData,
	input  logic         instrWait,
	// apb data port
	output corePkg::word paddr,
	output corePkg::word pwdata,
	input  corePkg::word prdata,
	output logic         psel,
	output logic         penable,
	output logic         pwrite,
	input  logic         pready
);
	// fetch
	corePkg::word pc;
	corePkg::word pcPlus4F;
	corePkg::word nextPc;
	// decode
	corePkg::word instrD;
	corePkg::word pcPlus4D;
	corePkg::regAddr rsD;
	corePkg::regAddr rtD;
	corePkg::regAddr rdD;
	corePkg::word immD;
	corePkg::decodeCtrl ctrlD;
	logic illegalD;
	corePkg::word readDataA;
	corePkg::word readDataB;
	corePkg::word jrTargetD;
	corePkg::word jumpTargetD;
	logic jumpTakenD;
	// execute
	corePkg::decodeToExec regE;
	corePkg::word srcAE;
	corePkg::word srcBE;
	corePkg::word aluBE;
	corePkg::word aluResultE;
	corePkg::word branchTargetE;
	corePkg::regAddr destE;
	logic zeroE;
	logic branchTakenE;
	// memory
	corePkg::execToMem regM;
	corePkg::execToMem memReq;
	corePkg::word loadData;
	corePkg::word resultM;
	logic memServed;
	logic apbDone;
	logic dataStall;
	// writeback
	corePkg::memToWb regW;
	// hazard controls
	corePkg::fwdSel fwdA;
	corePkg::fwdSel fwdB;
	logic fwdJr;
	logic stallFD;
	logic flushD;
	logic flushE;
	logic freeze;

	////////////////////
	// fetch
	////////////////////

	assign instrAddr = pc;
	assign pcPlus4F = pc + 32'd4;

	// older redirect first
	always_comb begin
		if (branchTakenE) begin
			nextPc = branchTargetE;
		end else if (jumpTakenD) begin
			nextPc = jumpTargetD;
		end else begin
			nextPc = pcPlus4F;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else if (!freeze && !stallFD) begin
			pc <= nextPc;
		end
	end

	// fetch to decode with a nop in place of the wrong-path word
	always_ff @(posedge clk) begin
		if (reset) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!freeze) begin
			if (flushD || jumpTakenD) begin
				instrD <= '0;
			end else if (!stallFD) begin
				instrD <= instrData;
				pcPlus4D <= pcPlus4F;
			end
		end
	end

	////////////////////
	// decode
	////////////////////

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};

	controlDecode decoder (
		.instr(instrD),
		.ctrl(ctrlD),
		.illegal(illegalD)
	);

	regFile #(
		.regCount(regCount)
	) regs (
		.clk(clk),
		.writeEnable(regW.regWrite),
		.writeAddr(regW.dest),
		.writeData(regW.result),
		.readAddrA(rsD),
		.readAddrB(rtD),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// j and jr leave from decode
	assign jrTargetD = fwdJr ? regM.aluResult : readDataA;
	assign jumpTargetD = ctrlD.jumpReg ? jrTargetD : {pcPlus4D[31:28], instrD[25:0], 2'b00};
	assign jumpTakenD = (ctrlD.jump || ctrlD.jumpReg) && !stallFD;

	always_ff @(posedge clk) begin
		if (reset) begin
			regE <= '0;
		end else if (!freeze) begin
			if (flushD || flushE) begin
				regE <= '0;
			end else begin
				regE.ctrl <= ctrlD;
				regE.pcPlus4 <= pcPlus4D;
				regE.opA <= readDataA;
				regE.opB <= readDataB;
				regE.imm <= immD;
				regE.rs <= rsD;
				regE.rt <= rtD;
				regE.rd <= rdD;
			end
		end
	end

	////////////////////
	// execute
	////////////////////

	always_comb begin
		case (fwdA)
			corePkg::fwdMem: srcAE = regM.aluResult;
			corePkg::fwdWb: srcAE = regW.result;
			default: srcAE = regE.opA;
		endcase
		case (fwdB)
			corePkg::fwdMem: srcBE = regM.aluResult;
			corePkg::fwdWb: srcBE = regW.result;
			default: srcBE = regE.opB;
		endcase
	end

	assign aluBE = regE.ctrl.aluSrcImm ? regE.imm : srcBE;

	alu execAlu (
		.op(regE.ctrl.aluOp),
		.a(srcAE),
		.b(aluBE),
		.result(aluResultE),
		.zero(zeroE)
	);

	// beq resolved here against the not-taken guess
	assign branchTakenE = regE.ctrl.branch && zeroE;
	assign branchTargetE = regE.pcPlus4 + {regE.imm[29:0], 2'b00};
	assign destE = regE.ctrl.regDst ? regE.rd : regE.rt;

	always_ff @(posedge clk) begin
		if (reset) begin
			regM <= '0;
		end else if (!freeze) begin
			regM.regWrite <= regE.ctrl.regWrite;
			regM.memToReg <= regE.ctrl.memToReg;
			regM.memWrite <= regE.ctrl.memWrite;
			regM.aluResult <= aluResultE;
			regM.storeData <= srcBE;
			regM.dest <= destE;
		end
	end

	////////////////////
	// memory
	////////////////////

	assign apbDone = psel && penable && pready;

	// transfer already done while a fetch wait holds the stage
	always_ff @(posedge clk) begin
		if (reset) begin
			memServed <= 1'b0;
		end else if (!freeze) begin
			memServed <= 1'b0;
		end else if (apbDone) begin
			memServed <= 1'b1;
		end
	end

	// no second transfer for the same entry
	always_comb begin
		memReq = regM;
		if (memServed) begin
			memReq.memWrite = 1'b0;
			memReq.memToReg = 1'b0;
		end
	end

	apbDataPort dataPort (
		.clk(clk),
		.reset(reset),
		.req(memReq),
		.prdata(prdata),
		.pready(pready),
		.loadData(loadData),
		.dataStall(dataStall),
		.paddr(paddr),
		.pwdata(pwdata),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite)
	);

	assign resultM = regM.memToReg ? loadData : regM.aluResult;

	always_ff @(posedge clk) begin
		if (reset) begin
			regW <= '0;
		end else if (!freeze) begin
			regW.regWrite <= regM.regWrite;
			regW.result <= resultM;
			regW.dest <= regM.dest;
		end
	end

	////////////////////
	// hazards
	////////////////////

	hazardUnit hazards (
		.clk(clk),
		.reset(reset),
		.rsD(rsD),
		.rtD(rtD),
		.jumpRegD(ctrlD.jumpReg),
		.rsE(regE.rs),
		.rtE(regE.rt),
		.destE(destE),
		.regWriteE(regE.ctrl.regWrite),
		.memToRegE(regE.ctrl.memToReg),
		.branchTakenE(branchTakenE),
		.destM(regM.dest),
		.regWriteM(regM.regWrite),
		.memToRegM(regM.memToReg),
		.destW(regW.dest),
		.regWriteW(regW.regWrite),
		.instrWait(instrWait),
		.dataStall(dataStall),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdJr(fwdJr),
		.stallFD(stallFD),
		.flushD(flushD),
		.flushE(flushE),
		.freeze(freeze)
	);

	// an undecodable word enters execute only as a bubble
	assert property (@(posedge clk) disable iff (reset)
		illegalD && !freeze |=> regE.ctrl == '0);

endmodule

/* testbench/tbCore.sv */
module tbCore;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int memWords = 64;
	localparam int timeoutCycles = 2000;
	localparam int settleCycles = 60;

	logic clk;
	logic reset;
	corePkg::word instrAddr;
	corePkg::word instrData;
	logic instrWait;
	corePkg::word paddr;
	corePkg::word pwdata;
	corePkg::word prdata;
	logic psel;
	logic penable;
	logic pwrite;
	logic pready;

	// instruction rom and apb slave memory
	corePkg::word rom [memWords];
	corePkg::word dmem [memWords];
	// word addresses presented on the fetch port
	logic visited [memWords];

	// stores completed on apb
	corePkg::word storeAddr [$];
	corePkg::word storeData [$];
	corePkg::word expAddr [$];
	corePkg::word expData [$];

	int mismatches;
	int timeouts;
	logic randomWaits;
	logic holdFetch;
	int fetchWaitLeft;
	int apbWaitLeft;
	corePkg::word setupAddr;
	corePkg::word setupData;
	logic setupWrite;

	mipsCore #(
		.resetPc('0),
		.regCount(32)
	) dut (
		.clk(clk),
		.reset(reset),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.instrWait(instrWait),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pready(pready)
	);

	always #10 clk = ~clk;

	// both memories answer in the same cycle
	assign instrData = rom[instrAddr[7:2]];
	assign prdata = dmem[paddr[7:2]];

	////////////////////
	// checks
	////////////////////

	task automatic checkWord(input string name, input corePkg::word expected,
		input corePkg::word actual);
		if (actual !== expected) begin
			mismatches++;
			$display("** Error at %0t: %s expected 0x%08h, received 0x%08h",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatches++;
			$display("** Error at %0t: %s expected %b, received %b",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			mismatches++;
			$display("** Error at %0t: %s expected %0d, received %0d",
				$time, name, expected, actual);
		end
	endtask

	////////////////////
	// memory models
	////////////////////

	// fetch waits of 0 to 3 cycles per accepted fetch in random mode
	always @(posedge clk) begin
		if (holdFetch) begin
			instrWait <= 1'b1;
		end else if (fetchWaitLeft != 0) begin
			instrWait <= 1'b1;
			fetchWaitLeft--;
		end else begin
			instrWait <= 1'b0;
			if (randomWaits) begin
				fetchWaitLeft = $urandom % 4;
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && !instrWait) begin
			visited[instrAddr[7:2]] = 1'b1;
		end
	end

	// apb slave
	always @(posedge clk) begin
		if (reset) begin
			pready <= 1'b0;
			apbWaitLeft = 0;
		end else if (psel && !penable) begin
			// setup phase latches what must stay put
			setupAddr = paddr;
			setupData = pwdata;
			setupWrite = pwrite;
			apbWaitLeft = randomWaits ? ($urandom % 4) : 0;
			pready <= (apbWaitLeft == 0);
		end else if (psel && penable) begin
			checkWord("paddr", setupAddr, paddr);
			checkWord("pwdata", setupData, pwdata);
			checkBit("pwrite", setupWrite, pwrite);
			if (pready) begin
				if (pwrite) begin
					dmem[paddr[7:2]] = pwdata;
					storeAddr.push_back(paddr);
					storeData.push_back(pwdata);
				end
				pready <= 1'b0;
			end else begin
				apbWaitLeft--;
				pready <= (apbWaitLeft == 0);
			end
		end
	end

	////////////////////
	// program helpers
	////////////////////

	function automatic corePkg::word rType(input int rs, input int rt, input int rd,
		input corePkg::opField funct);
		return {corePkg::opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic corePkg::word iType(input corePkg::opField op, input int rs,
		input int rt, input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic corePkg::word jType(input int target);
		return {corePkg::opJ, 26'(target)};
	endfunction

	// reset goes high and the core is in reset after this
	task automatic holdReset();
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
	endtask

	task automatic clearMemories();
		int i;
		for (i = 0; i < memWords; i++) begin
			rom[i] = '0;
			// pattern over the whole index
			dmem[i] = 32'hDA000000 | (i << 8) | i;
		end
		expAddr.delete();
		expData.delete();
	endtask

	task automatic expectStore(input corePkg::word addr, input corePkg::word data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// release reset then collect and compare the stores
	task automatic runProgram(input string name);
		int i;
		int cycles;
		int count;
		storeAddr.delete();
		storeData.delete();
		for (i = 0; i < memWords; i++) begin
			visited[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		cycles = 0;
		while (storeAddr.size() < expAddr.size() && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (storeAddr.size() < expAddr.size()) begin
			timeouts++;
			$display("%s: timed out after %0d cycles, saw %0d of %0d stores",
				name, cycles, storeAddr.size(), expAddr.size());
		end
		// anything arriving now is an extra store
		cycles = 0;
		while (cycles < settleCycles) begin
			@(negedge clk);
			cycles++;
		end
		checkCount({name, " store count"}, expAddr.size(), storeAddr.size());
		count = (storeAddr.size() < expAddr.size()) ? storeAddr.size() : expAddr.size();
		for (i = 0; i < count; i++) begin
			checkWord($sformatf("%s paddr[%0d]", name, i), expAddr[i], storeAddr[i]);
			checkWord($sformatf("%s pwdata[%0d]", name, i), expData[i], storeData[i]);
		end
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic testResetState();
		holdFetch = 1'b1;
		holdReset();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		// fetch still waiting so nothing accepted yet
		checkBit("psel", 1'b0, psel);
		checkBit("penable", 1'b0, penable);
		checkBit("pwrite", 1'b0, pwrite);
		checkWord("instrAddr", '0, instrAddr);
		holdFetch = 1'b0;
	endtask

	// every result feeds the next instruction
	task automatic testAluChain();
		holdReset();
		clearMemories();
		rom[0] = iType(corePkg::opAddiu, 0, 1, 5);
		rom[1] = iType(corePkg::opAddiu, 1, 2, 7);
		rom[2] = rType(1, 2, 3, corePkg::fnAddu);
		rom[3] = iType(corePkg::opSw, 0, 3, 0);
		rom[4] = rType(3, 1, 4, corePkg::fnSubu);
		rom[5] = rType(4, 3, 5, corePkg::fnOr);
		rom[6] = rType(5, 2, 6, corePkg::fnAnd);
		rom[7] = iType(corePkg::opSw, 0, 6, 4);
		rom[8] = rType(4, 3, 7, corePkg::fnSlt);
		rom[9] = rType(0, 5, 8, corePkg::fnSubu);
		rom[10] = rType(8, 7, 9, corePkg::fnSlt);
		rom[11] = iType(corePkg::opSw, 0, 5, 8);
		rom[12] = iType(corePkg::opSw, 0, 8, 12);
		rom[13] = iType(corePkg::opSw, 0, 9, 16);
		rom[14] = rType(7, 9, 10, corePkg::fnAddu);
		rom[15] = iType(corePkg::opSw, 0, 10, 20);
		rom[16] = iType(corePkg::opBeq, 0, 0, -1);
		expectStore(32'd0, 32'd17);
		expectStore(32'd4, 32'd12);
		expectStore(32'd8, 32'd29);
		// 0 - 29
		expectStore(32'd12, 32'hFFFFFFE3);
		// signed compare of -29 against 1
		expectStore(32'd16, 32'd1);
		expectStore(32'd20, 32'd2);
		runProgram("alu chain");
	endtask

	task automatic testLoadUse();
		holdReset();
		clearMemories();
		dmem[1] = 32'd100;
		dmem[2] = 32'd23;
		rom[0] = iType(corePkg::opAddiu, 0, 1, 4);
		rom[1] = iType(corePkg::opLw, 1, 2, 0);
		rom[2] = rType(2, 1, 3, corePkg::fnAddu);
		rom[3] = iType(corePkg::opLw, 1, 4, 4);
		rom[4] = rType(4, 2, 5, corePkg::fnSubu);
		rom[5] = iType(corePkg::opSw, 0, 3, 32);
		rom[6] = iType(corePkg::opSw, 0, 5, 36);
		rom[7] = iType(corePkg::opLw, 0, 6, 32);
		rom[8] = iType(corePkg::opSw, 0, 6, 40);
		rom[9] = iType(corePkg::opBeq, 0, 0, -1);
		expectStore(32'd32, 32'd104);
		// 23 - 100
		expectStore(32'd36, 32'hFFFFFFB3);
		expectStore(32'd40, 32'd104);
		runProgram("load use");
	endtask

	// markers at 48..56 sit on the wrong path
	task automatic testBranches();
		holdReset();
		clearMemories();
		rom[0] = iType(corePkg::opAddiu, 0, 1, 3);
		rom[1] = iType(corePkg::opAddiu, 0, 2, 3);
		rom[2] = iType(corePkg::opBeq, 1, 2, 3);
		rom[3] = iType(corePkg::opSw, 0, 1, 48);
		rom[4] = iType(corePkg::opSw, 0, 2, 52);
		rom[5] = iType(corePkg::opSw, 0, 0, 56);
		rom[6] = iType(corePkg::opAddiu, 0, 3, 9);
		rom[7] = iType(corePkg::opBeq, 3, 1, 1);
		rom[8] = iType(corePkg::opSw, 0, 3, 60);
		rom[9] = iType(corePkg::opAddiu, 3, 4, 1);
		rom[10] = iType(corePkg::opSw, 0, 4, 64);
		rom[11] = iType(corePkg::opBeq, 0, 0, -1);
		expectStore(32'd60, 32'd9);
		expectStore(32'd64, 32'd10);
		runProgram("branches");
	endtask

	task automatic testJumps();
		holdReset();
		clearMemories();
		rom[0] = iType(corePkg::opAddiu, 0, 1, 24);
		rom[1] = rType(1, 0, 0, corePkg::fnJr);
		rom[2] = iType(corePkg::opSw, 0, 1, 80);
		rom[6] = iType(corePkg::opAddiu, 0, 2, 77);
		rom[7] = jType(12);
		rom[8] = iType(corePkg::opSw, 0, 2, 84);
		rom[12] = iType(corePkg::opSw, 0, 2, 88);
		rom[13] = iType(corePkg::opAddiu, 0, 3, 72);
		rom[14] = iType(corePkg::opSw, 0, 3, 92);
		rom[15] = iType(corePkg::opLw, 0, 4, 92);
		// jr right behind a load
		rom[16] = rType(4, 0, 0, corePkg::fnJr);
		rom[17] = iType(corePkg::opSw, 0, 4, 100);
		rom[18] = iType(corePkg::opSw, 0, 4, 96);
		rom[19] = iType(corePkg::opBeq, 0, 0, -1);
		expectStore(32'd88, 32'd77);
		expectStore(32'd92, 32'd72);
		expectStore(32'd96, 32'd72);
		runProgram("jumps");
		checkBit("jr target 0x18 fetched", 1'b1, visited[6]);
		checkBit("j target 0x30 fetched", 1'b1, visited[12]);
		checkBit("jr target 0x48 fetched", 1'b1, visited[18]);
		// words past the squashed slot are never fetched
		checkBit("word 0x0c past jr fetched", 1'b0, visited[3]);
		checkBit("word 0x24 past j fetched", 1'b0, visited[9]);
	endtask

	task automatic testRandomWaits();
		randomWaits = 1'b1;
		testAluChain();
		testLoadUse();
		testBranches();
		testJumps();
		randomWaits = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instrWait = 1'b1;
		pready = 1'b0;
		randomWaits = 1'b0;
		holdFetch = 1'b1;
		fetchWaitLeft = 0;
		apbWaitLeft = 0;
		mismatches = 0;
		timeouts = 0;
		void'($urandom(83));
		clearMemories();

		testResetState();
		testAluChain();
		testLoadUse();
		testBranches();
		testJumps();
		testRandomWaits();

		$display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* all.f */
logic/corePkg.sv
logic/hazardUnit.sv
logic/regFile.sv
logic/alu.sv
logic/controlDecode.sv
logic/apbDataPort.sv
logic/mipsCore.sv
testbench/tbCore.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - logic/corePkg.sv
  - logic/hazardUnit.sv
  - logic/regFile.sv
  - logic/alu.sv
  - logic/controlDecode.sv
  - logic/apbDataPort.sv
  - logic/mipsCore.sv
  - target: test
    files:
      - testbench/tbCore.sv
